// File: hdl/pst_vreg_defs.svh
/*
  Vector register state entry
  Lane counts and field widths shared by the RTL and the testbench
*/
`ifndef PST_VREG_DEFS_SVH
`define PST_VREG_DEFS_SVH

// Lane counts
`define PST_DIS_LANES 4
`define PST_RET_LANES 4

// Instruction id and register index widths
`define PST_IID_W  7
`define PST_AREG_W 5
`define PST_PREG_W 6

`endif

// File: hdl/pst_vreg_entry.sv
/*
  Physical vector register state entry
  Tracks one physical register from allocation to release and
  reports its release and rename recovery vectors
*/
`timescale 1ns/1ns
`include "pst_vreg_defs.svh"

module pst_vreg_entry (
  input  logic                     sm_clk,
  input  logic                     cpurst_b,
  input  logic                     flush,
  input  logic                     async_flush,
  input  logic                     sync_reset,
  input  logic                     reset_mapped,
  input  pst_vreg_pkg::areg_t      reset_dstv_reg,
  input  logic                     dealloc_vld,
  input  logic                     release_vld,
  input  logic                     wb_vld,
  input  pst_vreg_pkg::dis_lane_t  create_vld,
  input  pst_vreg_pkg::iid_t       dis_iid [`PST_DIS_LANES],
  input  pst_vreg_pkg::areg_t      dis_dstv_reg [`PST_DIS_LANES],
  input  pst_vreg_pkg::preg_t      dis_rel_vreg [`PST_DIS_LANES],
  input  pst_vreg_pkg::ret_lane_t  retire_updt_vld,
  input  pst_vreg_pkg::iid_t       retire_updt_iid [`PST_RET_LANES],
  input  pst_vreg_pkg::ret_lane_t  retire_lane_vld,
  output logic                     cur_state_dealloc,
  output logic                     cur_state_alloc_release,
  output logic                     retired_released_wb,
  output pst_vreg_pkg::areg_mask_t dreg,
  output pst_vreg_pkg::preg_mask_t rel_vreg_expand
);
  import pst_vreg_pkg::*;

  iid_t iid;
  logic retire_vld;
  logic state_alloc;
  logic state_retire;
  logic rel_retire;

  //====================
  // Information register and output expansion
  pst_vreg_info u_info (
    .sm_clk          (sm_clk),
    .cpurst_b        (cpurst_b),
    .sync_reset      (sync_reset),
    .reset_dstv_reg  (reset_dstv_reg),
    .create_vld      (create_vld),
    .dis_iid         (dis_iid),
    .dis_dstv_reg    (dis_dstv_reg),
    .dis_rel_vreg    (dis_rel_vreg),
    .state_retire    (state_retire),
    .rel_retire      (rel_retire),
    .iid             (iid),
    .dreg            (dreg),
    .rel_vreg_expand (rel_vreg_expand)
  );

  //====================
  // Early iid compare against the retire lanes
  pst_vreg_retire_match u_retire_match (
    .sm_clk          (sm_clk),
    .cpurst_b        (cpurst_b),
    .sync_reset      (sync_reset),
    .iid             (iid),
    .state_alloc     (state_alloc),
    .retire_updt_vld (retire_updt_vld),
    .retire_updt_iid (retire_updt_iid),
    .retire_lane_vld (retire_lane_vld),
    .retire_vld      (retire_vld)
  );

  //====================
  // Lifecycle and write-back FSMs
  pst_vreg_state u_state (
    .sm_clk                  (sm_clk),
    .cpurst_b                (cpurst_b),
    .flush                   (flush),
    .async_flush             (async_flush),
    .sync_reset              (sync_reset),
    .reset_mapped            (reset_mapped),
    .dealloc_vld             (dealloc_vld),
    .release_vld             (release_vld),
    .wb_vld                  (wb_vld),
    .create_vld              (create_vld),
    .retire_vld              (retire_vld),
    .state_alloc             (state_alloc),
    .state_retire            (state_retire),
    .rel_retire              (rel_retire),
    .cur_state_dealloc       (cur_state_dealloc),
    .cur_state_alloc_release (cur_state_alloc_release),
    .retired_released_wb     (retired_released_wb)
  );

endmodule

// File: hdl/pst_vreg_info.sv
/*
  Vector register entry information
  Captures iid, destination and released register from the creating
  dispatch lane and expands them to one-hot vectors
*/
`timescale 1ns/1ns
`include "pst_vreg_defs.svh"

module pst_vreg_info (
  input  logic                     sm_clk,
  input  logic                     cpurst_b,
  input  logic                     sync_reset,
  input  pst_vreg_pkg::areg_t      reset_dstv_reg,
  input  pst_vreg_pkg::dis_lane_t  create_vld,
  input  pst_vreg_pkg::iid_t       dis_iid [`PST_DIS_LANES],
  input  pst_vreg_pkg::areg_t      dis_dstv_reg [`PST_DIS_LANES],
  input  pst_vreg_pkg::preg_t      dis_rel_vreg [`PST_DIS_LANES],
  input  logic                     state_retire,
  input  logic                     rel_retire,
  output pst_vreg_pkg::iid_t       iid,
  output pst_vreg_pkg::areg_mask_t dreg,
  output pst_vreg_pkg::preg_mask_t rel_vreg_expand
);
  import pst_vreg_pkg::*;

  logic       create;
  iid_t       create_iid;
  areg_t      create_dstv_reg;
  preg_t      create_rel_vreg;
  areg_t      dstv_reg;
  preg_t      rel_vreg;
  areg_mask_t dstv_reg_onehot;
  preg_mask_t rel_vreg_onehot;

  assign create = |create_vld;

  //====================
  // Create data select
  // At most one lane creates, so an AND-OR mux is enough
  always_comb begin
    create_iid      = '0;
    create_dstv_reg = '0;
    create_rel_vreg = '0;
    for (int i = 0; i < `PST_DIS_LANES; i++) begin
      if (create_vld[i]) begin
        create_iid      = create_iid | dis_iid[i];
        create_dstv_reg = create_dstv_reg | dis_dstv_reg[i];
        create_rel_vreg = create_rel_vreg | dis_rel_vreg[i];
      end
    end
  end

  //====================
  // Information register
  always_ff @(posedge sm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      iid      <= '0;
      dstv_reg <= '0;
      rel_vreg <= '0;
    end else if (sync_reset) begin
      iid      <= '0;
      dstv_reg <= reset_dstv_reg;
      rel_vreg <= '0;
    end else if (create) begin
      iid      <= create_iid;
      dstv_reg <= create_dstv_reg;
      rel_vreg <= create_rel_vreg;
    end
  end

  //====================
  // One-hot outputs
  assign rel_vreg_onehot = preg_mask_t'(1) << rel_vreg;
  assign dstv_reg_onehot = areg_mask_t'(1) << dstv_reg;

  // Released register freed in the retiring cycle
  assign rel_vreg_expand = rel_retire ? rel_vreg_onehot : '0;

  // Rename table recovery while retired and not yet released
  assign dreg = state_retire ? dstv_reg_onehot : '0;

endmodule

// File: hdl/pst_vreg_pkg.sv
/*
  Vector register state entry types
  Field vectors, lane masks and the two state encodings
*/
`include "pst_vreg_defs.svh"

package pst_vreg_pkg;

  typedef logic [`PST_IID_W-1:0]         iid_t;
  typedef logic [`PST_AREG_W-1:0]        areg_t;
  typedef logic [`PST_PREG_W-1:0]        preg_t;
  typedef logic [(1<<`PST_AREG_W)-1:0]   areg_mask_t;
  typedef logic [(1<<`PST_PREG_W)-1:0]   preg_mask_t;
  typedef logic [`PST_DIS_LANES-1:0]     dis_lane_t;
  typedef logic [`PST_RET_LANES-1:0]     ret_lane_t;

  // Register lifecycle, one-hot
  typedef enum logic [4:0] {
    DEALLOC  = 5'b00001,
    WF_ALLOC = 5'b00010,
    ALLOC    = 5'b00100,
    RETIRE   = 5'b01000,
    RELEASE  = 5'b10000
  } lifecycle_e;

  // Value written back or not
  typedef enum logic {
    WB_IDLE = 1'b0,
    WB_DONE = 1'b1
  } wb_e;

endpackage

// File: hdl/pst_vreg_retire_match.sv
/*
  Retire iid match
  Compares the entry iid against each retire lane one cycle ahead
  and forms the retire strobe from the registered result
*/
`timescale 1ns/1ns
`include "pst_vreg_defs.svh"

module pst_vreg_retire_match (
  input  logic                    sm_clk,
  input  logic                    cpurst_b,
  input  logic                    sync_reset,
  input  pst_vreg_pkg::iid_t      iid,
  input  logic                    state_alloc,
  input  pst_vreg_pkg::ret_lane_t retire_updt_vld,
  input  pst_vreg_pkg::iid_t      retire_updt_iid [`PST_RET_LANES],
  input  pst_vreg_pkg::ret_lane_t retire_lane_vld,
  output logic                    retire_vld
);
  import pst_vreg_pkg::*;

  ret_lane_t match_updt;
  ret_lane_t match_q;

  // Compare only while allocated, so a match implies ALLOC
  always_comb begin
    for (int j = 0; j < `PST_RET_LANES; j++) begin
      match_updt[j] = state_alloc && (iid == retire_updt_iid[j]);
    end
  end

  // Each lane keeps its match until its next update
  always_ff @(posedge sm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      match_q <= '0;
    end else if (sync_reset) begin
      match_q <= '0;
    end else begin
      for (int j = 0; j < `PST_RET_LANES; j++) begin
        if (retire_updt_vld[j]) begin
          match_q[j] <= match_updt[j];
        end
      end
    end
  end

  assign retire_vld = |(retire_lane_vld & match_q);

endmodule

// File: hdl/pst_vreg_state.sv
/*
  Vector register lifecycle and write-back FSMs
  Follows the register through alloc, retire and release and
  derives the entry status outputs
*/
`timescale 1ns/1ns

module pst_vreg_state (
  input  logic                    sm_clk,
  input  logic                    cpurst_b,
  input  logic                    flush,
  input  logic                    async_flush,
  input  logic                    sync_reset,
  input  logic                    reset_mapped,
  input  logic                    dealloc_vld,
  input  logic                    release_vld,
  input  logic                    wb_vld,
  input  pst_vreg_pkg::dis_lane_t create_vld,
  input  logic                    retire_vld,
  output logic                    state_alloc,
  output logic                    state_retire,
  output logic                    rel_retire,
  output logic                    cur_state_dealloc,
  output logic                    cur_state_alloc_release,
  output logic                    retired_released_wb
);
  import pst_vreg_pkg::*;

  lifecycle_e life_q;
  lifecycle_e life_nxt;
  lifecycle_e life_rst;
  wb_e        wb_q;
  wb_e        wb_nxt;
  wb_e        wb_rst;
  logic       create;
  logic       state_release;
  logic       wb_done;

  assign create = |create_vld;

  //====================
  // Lifecycle FSM
  // Mapped registers come out of reset as retired and written back
  assign life_rst = reset_mapped ? RETIRE : DEALLOC;

  always_ff @(posedge sm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      life_q <= DEALLOC;
    end else if (sync_reset) begin
      life_q <= life_rst;
    end else begin
      life_q <= life_nxt;
    end
  end

  // Release wins over retire in ALLOC
  always_comb begin
    case (life_q)
      DEALLOC:  life_nxt = (dealloc_vld && !flush) ? WF_ALLOC : DEALLOC;
      WF_ALLOC: begin
        if (flush)       life_nxt = DEALLOC;
        else if (create) life_nxt = ALLOC;
        else             life_nxt = WF_ALLOC;
      end
      ALLOC: begin
        if (flush)                       life_nxt = DEALLOC;
        else if (release_vld && wb_done) life_nxt = DEALLOC;
        else if (release_vld)            life_nxt = RELEASE;
        else if (retire_vld)             life_nxt = RETIRE;
        else                             life_nxt = ALLOC;
      end
      RETIRE: begin
        if (release_vld && wb_done) life_nxt = DEALLOC;
        else if (release_vld)       life_nxt = RELEASE;
        else                        life_nxt = RETIRE;
      end
      RELEASE:  life_nxt = wb_done ? DEALLOC : RELEASE;
      default:  life_nxt = DEALLOC;
    endcase
  end

  assign cur_state_dealloc = (life_q == DEALLOC);
  assign state_alloc       = (life_q == ALLOC);
  assign state_retire      = (life_q == RETIRE);
  assign state_release     = (life_q == RELEASE);

  assign cur_state_alloc_release = state_alloc || state_release;

  //====================
  // Write-back FSM
  assign wb_rst = reset_mapped ? WB_DONE : WB_IDLE;

  // async_flush forces done ahead of everything else
  always_ff @(posedge sm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      wb_q <= WB_IDLE;
    end else if (async_flush) begin
      wb_q <= WB_DONE;
    end else if (sync_reset) begin
      wb_q <= wb_rst;
    end else if (create) begin
      wb_q <= WB_IDLE;
    end else begin
      wb_q <= wb_nxt;
    end
  end

  // Done clears once the lifecycle is back in DEALLOC
  always_comb begin
    case (wb_q)
      WB_IDLE: wb_nxt = wb_vld ? WB_DONE : WB_IDLE;
      WB_DONE: wb_nxt = cur_state_dealloc ? WB_IDLE : WB_DONE;
      default: wb_nxt = WB_IDLE;
    endcase
  end

  assign wb_done = (wb_q == WB_DONE);

  //====================
  // Status outputs
  // Retire strobe counts only while still allocated
  assign rel_retire = state_alloc && retire_vld;

  // Covers the instruction retiring in this very cycle
  assign retired_released_wb = (rel_retire || state_retire || state_release)
                               ? wb_done : 1'b1;

endmodule

// File: pst_vreg_entry.f
+incdir+hdl
hdl/pst_vreg_pkg.sv
hdl/pst_vreg_info.sv
hdl/pst_vreg_retire_match.sv
hdl/pst_vreg_state.sv
hdl/pst_vreg_entry.sv
tests/pst_vreg_entry_sva.sv
tests/pst_vreg_entry_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the vector register entry simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
  -f pst_vreg_entry.f \
  --top-module pst_vreg_entry_tb

./obj_dir/Vpst_vreg_entry_tb

// File: tests/pst_vreg_entry_sva.sv
/*
  Structural assertions for the vector register entry
  Bound to the top level, checks one-hot outputs and state exclusivity
*/
`timescale 1ns/1ns

module pst_vreg_entry_sva (
  input logic                     sm_clk,
  input logic                     cpurst_b,
  input pst_vreg_pkg::dis_lane_t  create_vld,
  input logic                     cur_state_dealloc,
  input logic                     cur_state_alloc_release,
  input pst_vreg_pkg::areg_mask_t dreg,
  input pst_vreg_pkg::preg_mask_t rel_vreg_expand
);

  // At most one dispatch lane creates the entry
  a_create_onehot: assert property (@(posedge sm_clk) disable iff (!cpurst_b)
    $onehot0(create_vld)) else $error("create_vld has more than one lane set");

  //====================
  // One-hot outputs
  a_rel_onehot: assert property (@(posedge sm_clk) disable iff (!cpurst_b)
    $onehot0(rel_vreg_expand)) else $error("rel_vreg_expand has more than one bit set");

  a_dreg_onehot: assert property (@(posedge sm_clk) disable iff (!cpurst_b)
    $onehot0(dreg)) else $error("dreg has more than one bit set");

  // Recovery vector only while retired
  a_dreg_state: assert property (@(posedge sm_clk) disable iff (!cpurst_b)
    (dreg != '0) |-> (!cur_state_dealloc && !cur_state_alloc_release))
    else $error("dreg is set outside the retired state");

  //====================
  // Status exclusivity
  a_state_excl: assert property (@(posedge sm_clk) disable iff (!cpurst_b)
    !(cur_state_dealloc && cur_state_alloc_release))
    else $error("dealloc and alloc_release status are both high");

endmodule

bind pst_vreg_entry pst_vreg_entry_sva u_sva (
  .sm_clk                  (sm_clk),
  .cpurst_b                (cpurst_b),
  .create_vld              (create_vld),
  .cur_state_dealloc       (cur_state_dealloc),
  .cur_state_alloc_release (cur_state_alloc_release),
  .dreg                    (dreg),
  .rel_vreg_expand         (rel_vreg_expand)
);

// File: tests/pst_vreg_entry_tb.sv
/*
  Testbench for the vector register state entry
  Runs allocate, retire, release, flush and reset sequences and
  compares the outputs with a cycle model on every falling edge
*/
`timescale 1ns/1ns
`include "pst_vreg_defs.svh"

module pst_vreg_entry_tb;
  import pst_vreg_pkg::*;

  logic       sm_clk;
  logic       cpurst_b;
  logic       flush;
  logic       async_flush;
  logic       sync_reset;
  logic       reset_mapped;
  areg_t      reset_dstv_reg;
  logic       dealloc_vld;
  logic       release_vld;
  logic       wb_vld;
  dis_lane_t  create_vld;
  iid_t       dis_iid [`PST_DIS_LANES];
  areg_t      dis_dstv_reg [`PST_DIS_LANES];
  preg_t      dis_rel_vreg [`PST_DIS_LANES];
  ret_lane_t  retire_updt_vld;
  iid_t       retire_updt_iid [`PST_RET_LANES];
  ret_lane_t  retire_lane_vld;
  logic       cur_state_dealloc;
  logic       cur_state_alloc_release;
  logic       retired_released_wb;
  areg_mask_t dreg;
  preg_mask_t rel_vreg_expand;

  // Reference model
  lifecycle_e  m_life;
  wb_e         m_wb;
  iid_t        m_iid;
  areg_t       m_dst;
  preg_t       m_rel;
  ret_lane_t   m_match;
  logic        m_retire;
  logic        m_rel_retire;
  // Fields of the last create
  iid_t        c_iid;
  logic [31:0] lfsr;

  pst_vreg_entry u_pst_vreg_entry (.*);

  always #50 sm_clk = ~sm_clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_val(input string name, input logic [63:0] got,
                           input logic [63:0] exp);
    assert (got === exp) else begin
      abort_run($sformatf("ERR %s got %h expected %h", name, got, exp));
    end
  endtask

  // Galois LFSR, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    int b;
    v = '0;
    for (b = 0; b < n; b++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  //====================
  // Cycle model of the entry
  assign m_retire     = |(retire_lane_vld & m_match);
  assign m_rel_retire = (m_life == ALLOC) && m_retire;

  always @(posedge sm_clk or negedge cpurst_b) begin : ref_model
    int k;
    if (!cpurst_b) begin
      m_life  <= DEALLOC;
      m_wb    <= WB_IDLE;
      m_iid   <= '0;
      m_dst   <= '0;
      m_rel   <= '0;
      m_match <= '0;
    end else begin
      for (k = 0; k < `PST_RET_LANES; k++) begin
        if (retire_updt_vld[k])
          m_match[k] <= (m_life == ALLOC) && (m_iid == retire_updt_iid[k]);
      end
      for (k = 0; k < `PST_DIS_LANES; k++) begin
        if (create_vld[k]) begin
          m_iid <= dis_iid[k];
          m_dst <= dis_dstv_reg[k];
          m_rel <= dis_rel_vreg[k];
        end
      end
      if (sync_reset) begin
        m_match <= '0;
        m_iid   <= '0;
        m_dst   <= reset_dstv_reg;
        m_rel   <= '0;
      end
      // Lifecycle
      if (sync_reset)
        m_life <= reset_mapped ? RETIRE : DEALLOC;
      else if (flush && (m_life == WF_ALLOC || m_life == ALLOC))
        m_life <= DEALLOC;
      else if (m_life == DEALLOC && dealloc_vld && !flush)
        m_life <= WF_ALLOC;
      else if (m_life == WF_ALLOC && |create_vld)
        m_life <= ALLOC;
      else if ((m_life == ALLOC || m_life == RETIRE) && release_vld)
        m_life <= (m_wb == WB_DONE) ? DEALLOC : RELEASE;
      else if (m_life == ALLOC && m_retire)
        m_life <= RETIRE;
      else if (m_life == RELEASE && m_wb == WB_DONE)
        m_life <= DEALLOC;
      // Write-back
      if (async_flush)
        m_wb <= WB_DONE;
      else if (sync_reset)
        m_wb <= reset_mapped ? WB_DONE : WB_IDLE;
      else if (|create_vld)
        m_wb <= WB_IDLE;
      else if (m_wb == WB_DONE && m_life == DEALLOC)
        m_wb <= WB_IDLE;
      else if (wb_vld)
        m_wb <= WB_DONE;
    end
  end

  always @(negedge sm_clk) begin
    if (cpurst_b) begin
      check_val("cur_state_dealloc", 64'(cur_state_dealloc), 64'(m_life == DEALLOC));
      check_val("cur_state_alloc_release", 64'(cur_state_alloc_release),
                64'(m_life == ALLOC || m_life == RELEASE));
      check_val("retired_released_wb", 64'(retired_released_wb),
                64'((m_rel_retire || m_life == RETIRE || m_life == RELEASE) ?
                    (m_wb == WB_DONE) : 1'b1));
      check_val("dreg", 64'(dreg),
                64'((m_life == RETIRE) ? (areg_mask_t'(1) << m_dst) : '0));
      check_val("rel_vreg_expand", 64'(rel_vreg_expand),
                64'(m_rel_retire ? (preg_mask_t'(1) << m_rel) : '0));
    end
  end

  //====================
  // Stimulus helpers
  // Next rising edge, strobes back to idle
  task automatic step;
    @(posedge sm_clk);
    flush           <= 1'b0;
    async_flush     <= 1'b0;
    sync_reset      <= 1'b0;
    dealloc_vld     <= 1'b0;
    release_vld     <= 1'b0;
    wb_vld          <= 1'b0;
    create_vld      <= '0;
    retire_updt_vld <= '0;
    retire_lane_vld <= '0;
  endtask

  task automatic idle(input int n);
    repeat (n) step();
  endtask

  task automatic create_entry;
    logic [31:0] v;
    logic [31:0] lane;
    int i;
    step();
    lane = rand_bits(2);
    for (i = 0; i < `PST_DIS_LANES; i++) begin
      v = rand_bits(`PST_IID_W);
      dis_iid[i] <= v[`PST_IID_W-1:0];
      if (i == int'(lane[1:0]))
        c_iid = v[`PST_IID_W-1:0];
      v = rand_bits(`PST_AREG_W);
      dis_dstv_reg[i] <= v[`PST_AREG_W-1:0];
      v = rand_bits(`PST_PREG_W);
      dis_rel_vreg[i] <= v[`PST_PREG_W-1:0];
    end
    create_vld <= dis_lane_t'(1) << lane[1:0];
  endtask

  // Update on a random lane, then that lane's strobe one cycle later
  task automatic retire_on_lane(input logic hit);
    logic [31:0] lane;
    lane = rand_bits(2);
    step();
    retire_updt_vld                <= ret_lane_t'(1) << lane[1:0];
    retire_updt_iid[int'(lane[1:0])] <= hit ? c_iid : ~c_iid;
    step();
    retire_lane_vld <= ret_lane_t'(1) << lane[1:0];
  endtask

  task automatic wait_dealloc(input int limit);
    int n;
    n = 0;
    @(negedge sm_clk);
    while (!cur_state_dealloc) begin
      if (n == limit)
        abort_run("timeout: cur_state_dealloc did not rise");
      step();
      @(negedge sm_clk);
      n++;
    end
  endtask

  //====================
  // Test sequence
  initial begin : stimulus
    logic [31:0] v;
    int i;
    sm_clk          = 1'b0;
    cpurst_b        = 1'b0;
    flush           = 1'b0;
    async_flush     = 1'b0;
    sync_reset      = 1'b0;
    reset_mapped    = 1'b0;
    reset_dstv_reg  = '0;
    dealloc_vld     = 1'b0;
    release_vld     = 1'b0;
    wb_vld          = 1'b0;
    create_vld      = '0;
    retire_updt_vld = '0;
    retire_lane_vld = '0;
    c_iid           = '0;
    lfsr            = 32'h5c80_4750;
    for (i = 0; i < `PST_DIS_LANES; i++) begin
      dis_iid[i]      = '0;
      dis_dstv_reg[i] = '0;
      dis_rel_vreg[i] = '0;
      retire_updt_iid[i] = '0;
    end
    repeat (5) @(posedge sm_clk);
    cpurst_b <= 1'b1;
    idle(2);

    // Allocate, miss on retire, then hit
    step();
    dealloc_vld <= 1'b1;
    create_entry();
    idle(1);
    retire_on_lane(1'b0);
    idle(1);
    retire_on_lane(1'b1);
    idle(2);

    // Release ahead of write-back
    step();
    release_vld <= 1'b1;
    idle(2);
    step();
    wb_vld <= 1'b1;
    wait_dealloc(4);

    // Release after write-back
    step();
    dealloc_vld <= 1'b1;
    create_entry();
    step();
    wb_vld <= 1'b1;
    step();
    release_vld <= 1'b1;
    wait_dealloc(3);

    // Flush while allocated
    step();
    dealloc_vld <= 1'b1;
    create_entry();
    step();
    flush <= 1'b1;
    wait_dealloc(3);

    // Mapped sync reset, then release
    step();
    v = rand_bits(`PST_AREG_W);
    sync_reset     <= 1'b1;
    reset_mapped   <= 1'b1;
    reset_dstv_reg <= v[`PST_AREG_W-1:0];
    step();
    reset_mapped <= 1'b0;
    idle(1);
    step();
    release_vld <= 1'b1;
    wait_dealloc(3);

    // async_flush forces write-back during an allocation
    step();
    dealloc_vld <= 1'b1;
    create_entry();
    step();
    async_flush <= 1'b1;
    step();
    release_vld <= 1'b1;
    wait_dealloc(3);

    idle(2);
    $display("All tests passed");
    $finish;
  end

endmodule
